/* vdma_settings.svh */
// video dma frame writer constants
`ifndef VDMA_SETTINGS_SVH
`define VDMA_SETTINGS_SVH

// one rgb pixel
`define VDMA_PIX_W        24
// pixels packed per axi beat, top byte left zero
`define VDMA_PIX_PER_BEAT 5
`define VDMA_DATA_W       128
`define VDMA_ADDR_W       32
// axi4 awlen field
`define VDMA_LEN_W        8
// full burst length in beats
`define VDMA_BURST_BEATS  8
// bytes between line starts
`define VDMA_LINE_STRIDE  4096
`define VDMA_FIFO_DEPTH   32
// free slots left when almost full rises
`define VDMA_AFULL_MARGIN 4
`define VDMA_BEAT_BYTES   16

`endif

/* vdma_pkg.sv */
// video dma shared types
`default_nettype none

`include "vdma_settings.svh"

package vdma_pkg;

    // one packed axi data beat
    typedef logic [`VDMA_DATA_W-1:0] beat_t;

    // byte address
    typedef logic [`VDMA_ADDR_W-1:0] addr_t;

    // beats in a burst minus one
    typedef logic [`VDMA_LEN_W-1:0] len_t;

    // fifo level, 0 up to full depth
    typedef logic [$clog2(`VDMA_FIFO_DEPTH+1)-1:0] count_t;

    // burst scheduler
    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_BUSY
    } sched_state_e;

    // axi write channel sequencer
    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } wr_state_e;

endpackage

`default_nettype wire

/* burst_req_if.sv */
// burst request channel
`timescale 1ns/1ps
`default_nettype none

interface burst_req_if
    import vdma_pkg::*;
();

    // request held until req_ready
    logic  req_valid;
    logic  req_ready;
    // first beat byte address
    addr_t req_addr;
    // beats minus one
    len_t  req_len;
    // one cycle at write response
    logic  done;

    modport sched (
        output req_valid, req_addr, req_len,
        input  req_ready, done
    );

    modport writer (
        input  req_valid, req_addr, req_len,
        output req_ready, done
    );

endinterface

`default_nettype wire

/* pixel_packer.sv */
// pixel to beat packer
`timescale 1ns/1ps
`default_nettype none

`include "vdma_settings.svh"

module pixel_packer
    import vdma_pkg::*;
(
    input  wire                    clock,
    input  wire                    arst_n,
    input  wire                    vsync,
    input  wire                    de,
    input  wire [`VDMA_PIX_W-1:0]  idata,
    input  wire [15:0]             hactive,
    output logic                   beat_valid,
    output beat_t                  beat,
    output logic                   line_end,
    output logic                   frame_start
);

    localparam int PACK_W = `VDMA_PIX_W * `VDMA_PIX_PER_BEAT;

    logic              vsync_d;
    logic              vs_rise;
    logic [2:0]        slot;
    logic [15:0]       col;
    logic [PACK_W-1:0] acc;
    logic [PACK_W-1:0] acc_nxt;
    logic              last_pix;
    logic              beat_full;
    logic              emit;

    assign vs_rise   = vsync & ~vsync_d;
    // last pixel of the line by column count
    assign last_pix  = (col == hactive - 16'd1);
    assign beat_full = (slot == 3'(`VDMA_PIX_PER_BEAT - 1));
    assign emit      = de && (beat_full || last_pix);

    // pixel k sits at bits 24k up
    always_comb begin
        acc_nxt = acc;
        acc_nxt[slot*`VDMA_PIX_W +: `VDMA_PIX_W] = idata;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            vsync_d     <= 1'b0;
            frame_start <= 1'b0;
            slot        <= '0;
            col         <= '0;
            acc         <= '0;
            beat_valid  <= 1'b0;
            line_end    <= 1'b0;
        end else begin
            vsync_d     <= vsync;
            frame_start <= vs_rise;
            beat_valid  <= 1'b0;
            line_end    <= 1'b0;
            if (vs_rise) begin
                // new frame restarts column and slot
                slot <= '0;
                col  <= '0;
                acc  <= '0;
            end else if (de) begin
                if (emit) begin
                    // cleared acc gives zero padding on a short beat
                    slot       <= '0;
                    acc        <= '0;
                    beat_valid <= 1'b1;
                end else begin
                    slot <= slot + 3'd1;
                    acc  <= acc_nxt;
                end
                if (last_pix) begin
                    col      <= '0;
                    line_end <= 1'b1;
                end else begin
                    col <= col + 16'd1;
                end
            end
        end
    end

    // beat payload, top byte zero
    always_ff @(posedge clock) begin
        if (emit) begin
            beat <= beat_t'(acc_nxt);
        end
    end

endmodule

`default_nettype wire

/* stream_fifo.sv */
// beat fifo with level and almost full
`timescale 1ns/1ps
`default_nettype none

`include "vdma_settings.svh"

module stream_fifo
    import vdma_pkg::*;
(
    input  wire    clock,
    input  wire    arst_n,
    input  wire    flush,
    input  wire    wr_en,
    input  wire    beat_t wr_data,
    input  wire    rd_en,
    output beat_t  rd_data,
    output logic   empty,
    output logic   almost_full,
    output count_t level
);

    localparam int DEPTH = `VDMA_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    beat_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             wr_ok;
    logic             rd_ok;

    assign full        = (level == count_t'(DEPTH));
    assign empty       = (level == '0);
    assign almost_full = (level >= count_t'(DEPTH - `VDMA_AFULL_MARGIN));

    // writes into a full fifo are lost
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // first word fall through
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            // pointers wrap on power of two depth
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            level <= level + count_t'(wr_ok) - count_t'(rd_ok);
        end
    end

    always_ff @(posedge clock) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // source kept de low under almost full, so no pixel was dropped
    assert property (@(posedge clock) disable iff (!arst_n) wr_en && !flush |-> !full);

    // writer only pulls a beat it sees at the head
    assert property (@(posedge clock) disable iff (!arst_n) rd_en && !flush |-> !empty);

endmodule

`default_nettype wire

/* burst_scheduler.sv */
// burst scheduler and address generator
`timescale 1ns/1ps
`default_nettype none

`include "vdma_settings.svh"

module burst_scheduler
    import vdma_pkg::*;
(
    input  wire          clock,
    input  wire          arst_n,
    input  wire          enable,
    input  wire addr_t   baseaddr,
    input  wire [15:0]   hactive,
    input  wire          frame_start,
    input  wire          line_end,
    input  wire count_t  level,
    burst_req_if.sched   req
);

    localparam int BURST = `VDMA_BURST_BEATS;

    sched_state_e state;
    addr_t        base;
    addr_t        offset;
    logic [15:0]  line_beats;
    logic [15:0]  remain;
    logic [15:0]  line_idx;
    logic [15:0]  burst_beats;
    count_t       lines_ready;
    logic         want_full;
    logic         want_tail;
    logic         issue;
    logic         line_done;

    // five pixels per beat, rounded up
    assign line_beats  = 16'((17'(hactive) + 17'd4) / 17'd5);
    assign burst_beats = 16'(req.req_len) + 16'd1;

    // full burst while enough beats are queued and the line has room
    assign want_full = (level >= count_t'(BURST)) && (remain >= 16'(BURST));
    // tail once the line's last beat has landed in the fifo
    assign want_tail = (lines_ready != '0) && (remain != '0) && (16'(level) >= remain);
    assign issue     = (state == S_IDLE) && enable && (want_full || want_tail);
    assign line_done = req.done && (burst_beats == remain);

    assign req.req_valid = (state == S_WAIT);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state       <= S_IDLE;
            base        <= '0;
            offset      <= '0;
            remain      <= '0;
            line_idx    <= '0;
            lines_ready <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (issue) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (req.req_ready) begin
                        state <= S_BUSY;
                    end
                end
                default: begin
                    if (req.done) begin
                        state <= S_IDLE;
                    end
                end
            endcase
            if (frame_start) begin
                // new frame starts at line 0 of the new base
                base        <= baseaddr;
                offset      <= '0;
                remain      <= line_beats;
                line_idx    <= '0;
                lines_ready <= '0;
            end else begin
                lines_ready <= lines_ready + count_t'(line_end) - count_t'(line_done);
                if (line_done) begin
                    line_idx <= line_idx + 16'd1;
                    offset   <= '0;
                    remain   <= line_beats;
                end else if (req.done) begin
                    offset <= offset + addr_t'(burst_beats) * addr_t'(`VDMA_BEAT_BYTES);
                    remain <= remain - burst_beats;
                end
            end
        end
    end

    // request payload, held through S_WAIT
    always_ff @(posedge clock) begin
        if (issue) begin
            req.req_len  <= want_full ? len_t'(BURST - 1) : len_t'(remain - 16'd1);
            req.req_addr <= base + addr_t'(line_idx) * addr_t'(`VDMA_LINE_STRIDE) + offset;
        end
    end

    // address and length hold until the writer accepts
    assert property (@(posedge clock) disable iff (!arst_n)
        req.req_valid && !req.req_ready |=> $stable(req.req_addr) && $stable(req.req_len));

endmodule

`default_nettype wire

/* axi_write_master.sv */
// axi4 write burst master
`timescale 1ns/1ps
`default_nettype none

`include "vdma_settings.svh"

module axi_write_master
    import vdma_pkg::*;
(
    input  wire         clock,
    input  wire         arst_n,
    input  wire beat_t  fifo_data,
    input  wire         fifo_empty,
    output logic        fifo_rd,
    burst_req_if.writer req,
    output addr_t       awaddr,
    output len_t        awlen,
    output logic        awvalid,
    output beat_t       wdata,
    output logic        wlast,
    output logic        wvalid,
    output logic        bready,
    output logic        bus_error,
    input  wire         awready,
    input  wire         wready,
    input  wire         bvalid,
    input  wire [1:0]   bresp
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    wr_state_e state;
    // beats left after the current one
    len_t      beat_cnt;
    // beats accepted since the address phase
    len_t      beats_sent;

    assign req.req_ready = (state == W_IDLE);
    assign awvalid       = (state == W_ADDR);

    // head beat of the fifo goes straight onto the bus
    assign wvalid  = (state == W_DATA) && !fifo_empty;
    assign wdata   = fifo_data;
    assign wlast   = wvalid && (beat_cnt == '0);
    assign fifo_rd = wvalid && wready;

    assign bready   = (state == W_RESP);
    assign req.done = bready && bvalid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= W_IDLE;
            beat_cnt   <= '0;
            beats_sent <= '0;
            bus_error  <= 1'b0;
        end else begin
            case (state)
                W_IDLE: begin
                    if (req.req_valid) begin
                        state    <= W_ADDR;
                        beat_cnt <= req.req_len;
                    end
                end
                W_ADDR: begin
                    if (awready) begin
                        state      <= W_DATA;
                        beats_sent <= '0;
                    end
                end
                W_DATA: begin
                    if (fifo_rd) begin
                        beats_sent <= beats_sent + 1'b1;
                        if (wlast) begin
                            state <= W_RESP;
                        end else begin
                            beat_cnt <= beat_cnt - 1'b1;
                        end
                    end
                end
                default: begin
                    if (bvalid) begin
                        state <= W_IDLE;
                        // sticky until reset
                        if (bresp != RESP_OKAY) begin
                            bus_error <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // address phase payload
    always_ff @(posedge clock) begin
        if (req.req_valid && req.req_ready) begin
            awaddr <= req.req_addr;
            awlen  <= req.req_len;
        end
    end

    // wlast exactly on beat awlen+1 of the burst
    assert property (@(posedge clock) disable iff (!arst_n)
        fifo_rd |-> (wlast == (beats_sent == awlen)));

endmodule

`default_nettype wire

/* frame_writer_top.sv */
// video dma frame writer top
`timescale 1ns/1ps
`default_nettype none

`include "vdma_settings.svh"

module frame_writer_top
    import vdma_pkg::*;
(
    input  wire                        clock,
    input  wire                        arst_n,
    input  wire                        enable,
    input  wire addr_t                 baseaddr,
    input  wire [15:0]                 hactive,
    // video input
    input  wire                        vsync,
    input  wire                        de,
    input  wire [`VDMA_PIX_W-1:0]      idata,
    output logic                       fifo_almost_full,
    // axi write address
    output addr_t                      awaddr,
    output len_t                       awlen,
    output logic [2:0]                 awsize,
    output logic [1:0]                 awburst,
    output logic                       awvalid,
    input  wire                        awready,
    // axi write data
    output beat_t                      wdata,
    output logic [`VDMA_DATA_W/8-1:0]  wstrb,
    output logic                       wlast,
    output logic                       wvalid,
    input  wire                        wready,
    // axi write response
    output logic                       bready,
    input  wire                        bvalid,
    input  wire [1:0]                  bresp,
    output logic                       bus_error
);

    logic   pk_valid;
    beat_t  pk_beat;
    logic   line_end;
    logic   frame_start;
    beat_t  fifo_head;
    logic   fifo_empty;
    logic   fifo_rd;
    count_t fifo_level;

    burst_req_if req_bus ();

    // full beats, incr bursts, no partial strobes
    assign awsize  = 3'($clog2(`VDMA_BEAT_BYTES));
    assign awburst = 2'b01;
    assign wstrb   = '1;

    pixel_packer packer0 (
        .clock       (clock),
        .arst_n      (arst_n),
        .vsync       (vsync),
        .de          (de),
        .idata       (idata),
        .hactive     (hactive),
        .beat_valid  (pk_valid),
        .beat        (pk_beat),
        .line_end    (line_end),
        .frame_start (frame_start)
    );

    // emptied at every frame start
    stream_fifo fifo0 (
        .clock       (clock),
        .arst_n      (arst_n),
        .flush       (frame_start),
        .wr_en       (pk_valid),
        .wr_data     (pk_beat),
        .rd_en       (fifo_rd),
        .rd_data     (fifo_head),
        .empty       (fifo_empty),
        .almost_full (fifo_almost_full),
        .level       (fifo_level)
    );

    burst_scheduler sched0 (
        .clock       (clock),
        .arst_n      (arst_n),
        .enable      (enable),
        .baseaddr    (baseaddr),
        .hactive     (hactive),
        .frame_start (frame_start),
        .line_end    (line_end),
        .level       (fifo_level),
        .req         (req_bus.sched)
    );

    axi_write_master writer0 (
        .clock      (clock),
        .arst_n     (arst_n),
        .fifo_data  (fifo_head),
        .fifo_empty (fifo_empty),
        .fifo_rd    (fifo_rd),
        .req        (req_bus.writer),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awvalid    (awvalid),
        .wdata      (wdata),
        .wlast      (wlast),
        .wvalid     (wvalid),
        .bready     (bready),
        .bus_error  (bus_error),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp)
    );

endmodule

`default_nettype wire

/* tb_tests.svh */
// frame writer directed tests

// vsync pulse, then lines of pixels with a short blank after each
task automatic send_frame(input int frame_id, input int lines, input int h);
    int stall;
    int l;
    int c;
    vsync = 1'b1;
    next_cycle();
    vsync = 1'b0;
    repeat (3) next_cycle();
    for (l = 0; l < lines; l++) begin
        for (c = 0; c < h; c++) begin
            stall = 0;
            // source holds off while the fifo is nearly full
            while (fifo_almost_full) begin
                de = 1'b0;
                stall++;
                if (stall > TIMEOUT) begin
                    report_failure("video source stuck behind fifo_almost_full");
                end
                next_cycle();
            end
            de    = 1'b1;
            idata = pixel_value(frame_id, l, c);
            next_cycle();
        end
        de = 1'b0;
        repeat (4) next_cycle();
    end
endtask

task automatic wait_bursts(input int n);
    int t;
    t = 0;
    while (b_count < n) begin
        t++;
        if (t > TIMEOUT) begin
            report_failure($sformatf("no write response %0d of %0d arrived", b_count + 1, n));
        end
        next_cycle();
    end
    repeat (2) next_cycle();
endtask

// full bursts while 8 beats remain, then one tail of the rest
task automatic check_bursts(input addr_t base, input int lines, input int h);
    int n;
    int l;
    int rem;
    int off;
    int len;
    n = 0;
    for (l = 0; l < lines; l++) begin
        rem = (h + 4) / 5;
        off = 0;
        while (rem > 0) begin
            len = (rem >= 8) ? 8 : rem;
            check_value($sformatf("awaddr of burst %0d", n), aw_addrs[n],
                        base + addr_t'(l * 4096 + off * 16));
            check_value($sformatf("awlen of burst %0d", n), aw_lens[n], len - 1);
            n++;
            off += len;
            rem -= len;
        end
    end
    check_value("burst count", aw_addrs.size(), n);
endtask

task automatic check_frame(input int frame_id, input addr_t base, input int lines,
                           input int h);
    int    beats;
    int    l;
    int    b;
    addr_t a;
    beats = (h + 4) / 5;
    for (l = 0; l < lines; l++) begin
        for (b = 0; b < beats; b++) begin
            a = base + addr_t'(l * 4096 + b * 16);
            check_value($sformatf("line %0d beat %0d written", l, b), written[mem_index(a)], 1);
            check_value($sformatf("line %0d beat %0d data", l, b), mem_data[mem_index(a)],
                        expect_beat(frame_id, l, b, h));
        end
    end
    check_value("beats written", w_count, lines * beats);
endtask

// 16 beats per line, two full bursts each
task automatic test_full_bursts();
    clear_memory();
    baseaddr = BASE_A;
    hactive  = 16'd80;
    send_frame(1, 4, 80);
    wait_bursts(8);
    check_bursts(BASE_A, 4, 80);
    check_frame(1, BASE_A, 4, 80);
endtask

// 5 beats per line, last one holds 3 pixels
task automatic test_tail_bursts();
    clear_memory();
    hactive = 16'd23;
    send_frame(2, 3, 23);
    wait_bursts(3);
    check_bursts(BASE_A, 3, 23);
    check_frame(2, BASE_A, 3, 23);
endtask

// same frame as the first test under random slave stalls
task automatic test_random_stalls();
    clear_memory();
    rand_mode = 1'b1;
    hactive   = 16'd80;
    send_frame(1, 4, 80);
    wait_bursts(8);
    rand_mode = 1'b0;
    check_bursts(BASE_A, 4, 80);
    check_frame(1, BASE_A, 4, 80);
endtask

// address channel blocked until the fifo nearly fills
task automatic test_back_pressure();
    int t;
    clear_memory();
    aw_hold = 1'b1;
    fork
        send_frame(3, 4, 80);
        begin
            t = 0;
            while (!fifo_almost_full) begin
                t++;
                if (t > TIMEOUT) begin
                    report_failure("fifo_almost_full never rose with awready held low");
                end
                next_cycle();
            end
            repeat (20) next_cycle();
            check_value("fifo_almost_full held", fifo_almost_full, 1);
            check_value("awvalid held under stall", awvalid, 1);
            // no data beat before the address is taken
            check_value("wvalid held under stall", wvalid, 0);
            aw_hold = 1'b0;
        end
    join
    wait_bursts(8);
    check_bursts(BASE_A, 4, 80);
    check_frame(3, BASE_A, 4, 80);
endtask

// new base restarts at line 0, and enable low blocks bursts
task automatic test_new_base();
    clear_memory();
    baseaddr = BASE_B;
    send_frame(4, 2, 80);
    wait_bursts(4);
    check_bursts(BASE_B, 2, 80);
    check_frame(4, BASE_B, 2, 80);
    clear_memory();
    enable   = 1'b0;
    baseaddr = BASE_C;
    send_frame(5, 1, 80);
    repeat (50) begin
        check_value("awvalid while disabled", awvalid, 0);
        next_cycle();
    end
    // nothing reached the slave during the whole disabled frame
    check_value("bursts while disabled", aw_addrs.size(), 0);
    enable = 1'b1;
    wait_bursts(2);
    check_bursts(BASE_C, 1, 80);
    check_frame(5, BASE_C, 1, 80);
endtask

// slverr on the first burst sets a sticky error
task automatic test_slave_error();
    clear_memory();
    check_value("bus_error before slverr", bus_error, 0);
    baseaddr = BASE_A;
    err_at   = 1;
    send_frame(6, 1, 80);
    wait_bursts(2);
    err_at = 0;
    check_value("bus_error after slverr", bus_error, 1);
    clear_memory();
    send_frame(7, 1, 80);
    wait_bursts(2);
    check_value("bus_error still set", bus_error, 1);
    check_frame(7, BASE_A, 1, 80);
endtask

/* tb_frame_writer.sv */
// frame writer testbench
`timescale 1ns/1ps
`default_nettype none

`include "vdma_settings.svh"

module tb_frame_writer
    import vdma_pkg::*;
();

    localparam int    TIMEOUT = 5000;
    localparam addr_t BASE_A  = 32'h1000_0000;
    localparam addr_t BASE_B  = 32'h2000_0000;
    localparam addr_t BASE_C  = 32'h3000_0000;

    logic                      clock;
    logic                      arst_n;
    logic                      enable;
    addr_t                     baseaddr;
    logic [15:0]               hactive;
    logic                      vsync;
    logic                      de;
    logic [`VDMA_PIX_W-1:0]    idata;
    logic                      fifo_almost_full;
    addr_t                     awaddr;
    len_t                      awlen;
    logic [2:0]                awsize;
    logic [1:0]                awburst;
    logic                      awvalid;
    logic                      awready;
    beat_t                     wdata;
    logic [`VDMA_DATA_W/8-1:0] wstrb;
    logic                      wlast;
    logic                      wvalid;
    logic                      wready;
    logic                      bready;
    logic                      bvalid;
    logic [1:0]                bresp;
    logic                      bus_error;

    // slave memory, indexed by base select and in-frame beat
    beat_t     mem_data [4096];
    logic      written  [4096];
    addr_t     aw_addrs [$];
    len_t      aw_lens  [$];
    int        w_count;
    int        b_count;
    logic [31:0] lfsr;
    logic      rand_mode;
    logic      aw_hold;
    // 1-based response number that gets slverr, 0 for none
    int        err_at;

    frame_writer_top dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t ns: %s, got %0h, expected %0h",
                                     $time, what, got, exp));
        end
    endtask

    // stimulus changes 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    // galois form of x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    // frame in the top byte, then line, then column
    function automatic logic [`VDMA_PIX_W-1:0] pixel_value(input int frame_id,
                                                          input int line, input int col);
        return {8'(frame_id), 4'(line), 12'(col)};
    endfunction

    // five pixels from bit 0 up, missing columns and top byte zero
    function automatic beat_t expect_beat(input int frame_id, input int line,
                                          input int beat_no, input int h);
        beat_t b;
        int    k;
        int    col;
        b = '0;
        for (k = 0; k < `VDMA_PIX_PER_BEAT; k++) begin
            col = beat_no * `VDMA_PIX_PER_BEAT + k;
            if (col < h) begin
                b[k*`VDMA_PIX_W +: `VDMA_PIX_W] = pixel_value(frame_id, line, col);
            end
        end
        return b;
    endfunction

    function automatic int mem_index(input addr_t a);
        return int'({a[29:28], a[13:4]});
    endfunction

    task automatic clear_memory();
        int i;
        for (i = 0; i < 4096; i++) begin
            written[i] = 1'b0;
        end
        aw_addrs.delete();
        aw_lens.delete();
        w_count = 0;
        b_count = 0;
    endtask

    // axi slave, samples handshakes mid-cycle and drives after the edge
    initial begin
        logic  aw_fire;
        logic  w_fire;
        logic  b_fire;
        logic  b0;
        logic  b1;
        addr_t cur_addr;
        len_t  cur_len;
        int    beat_no;
        logic  resp_due;
        int    resp_wait;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        bresp     = 2'b00;
        cur_addr  = '0;
        cur_len   = '0;
        beat_no   = 0;
        resp_due  = 1'b0;
        resp_wait = 0;
        forever begin
            @(negedge clock);
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            b_fire  = bvalid && bready;
            if (aw_fire) begin
                check_value("awaddr outside window",
                            {awaddr[31:30], awaddr[27:14], awaddr[3:0]}, 0);
                check_value("awsize", awsize, 3'd4);
                check_value("awburst", awburst, 2'b01);
                cur_addr = awaddr;
                cur_len  = awlen;
                beat_no  = 0;
                aw_addrs.push_back(awaddr);
                aw_lens.push_back(awlen);
            end
            if (w_fire) begin
                mem_data[mem_index(cur_addr + addr_t'(beat_no * 16))] = wdata;
                written[mem_index(cur_addr + addr_t'(beat_no * 16))]  = 1'b1;
                check_value($sformatf("wlast on beat %0d of awlen %0d", beat_no, cur_len),
                            wlast, beat_no == int'(cur_len));
                check_value("wstrb", wstrb, 16'hffff);
                beat_no++;
                w_count++;
                if (wlast) begin
                    resp_due  = 1'b1;
                    resp_wait = 0;
                    if (rand_mode) begin
                        take_bit(b0);
                        take_bit(b1);
                        resp_wait = int'({b1, b0});
                    end
                end
            end
            if (b_fire) begin
                b_count++;
            end
            next_cycle();
            if (b_fire) begin
                bvalid = 1'b0;
                bresp  = 2'b00;
            end
            if (resp_due) begin
                if (resp_wait == 0) begin
                    bvalid   = 1'b1;
                    bresp    = (b_count + 1 == err_at) ? 2'b10 : 2'b00;
                    resp_due = 1'b0;
                end else begin
                    resp_wait--;
                end
            end
            if (rand_mode) begin
                take_bit(b0);
                awready = b0 && !aw_hold;
                take_bit(b1);
                wready = b1;
            end else begin
                awready = !aw_hold;
                wready  = 1'b1;
            end
        end
    end

    `include "tb_tests.svh"

    initial begin
        arst_n    = 1'b0;
        enable    = 1'b1;
        baseaddr  = '0;
        hactive   = 16'd80;
        vsync     = 1'b0;
        de        = 1'b0;
        idata     = '0;
        rand_mode = 1'b0;
        aw_hold   = 1'b0;
        err_at    = 0;
        lfsr      = 32'heb8b_0c64;
        clear_memory();
        repeat (4) @(posedge clock);
        #2;
        // outputs quiet under reset
        check_value("awvalid in reset", awvalid, 0);
        check_value("wvalid in reset", wvalid, 0);
        check_value("bready in reset", bready, 0);
        check_value("fifo_almost_full in reset", fifo_almost_full, 0);
        check_value("bus_error in reset", bus_error, 0);
        check_value("req_valid in reset", dut0.req_bus.req_valid, 0);
        arst_n = 1'b1;
        next_cycle();
        test_full_bursts();
        test_tail_bursts();
        test_random_stalls();
        test_back_pressure();
        test_new_base();
        test_slave_error();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
vdma_pkg.sv
burst_req_if.sv
pixel_packer.sv
stream_fifo.sv
burst_scheduler.sv
axi_write_master.sv
frame_writer_top.sv
tb_frame_writer.sv

/* Bender.yml */
package:
  name: frame_writer

sources:
  - include_dirs:
      - .
    files:
      - vdma_pkg.sv
      - burst_req_if.sv
      - pixel_packer.sv
      - stream_fifo.sv
      - burst_scheduler.sv
      - axi_write_master.sv
      - frame_writer_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_frame_writer.sv
